// ==== hdl/errt_data_pkg.sv ====
package errt_data_pkg;

    // Thermometer code of one PAM4 level.
    localparam int SYM_W = 3;

    // Signed slicer error estimate.
    localparam int ERR_W = 8;

    localparam int FLAG_W = 3;

    // PRBS checker error bits per lane.
    localparam int PRBS_W = 2;

    localparam int REC_W = SYM_W + ERR_W + FLAG_W + PRBS_W;

    typedef struct packed {
        logic [PRBS_W-1:0]       prbs;
        logic [FLAG_W-1:0]       sd_flags;
        logic signed [ERR_W-1:0] error;
        logic [SYM_W-1:0]        symbol;
    } lane_rec_t;

    // One capture memory word, seen either as fields or as the raw stored bits.
    typedef union packed {
        lane_rec_t        rec;
        logic [REC_W-1:0] raw;
    } rec_word_u;

endpackage

// ==== hdl/errt_ctrl_pkg.sv ====
package errt_ctrl_pkg;

    localparam int MODE_W = 2;

    // Each capture window holds the frame before the trigger, the trigger frame and the one after.
    localparam int WIN_FRAMES = 3;

    // Mode n fires when the number of set trigger bits exceeds n.
    typedef enum logic [MODE_W-1:0] {
        MODE_GT0 = 2'd0,
        MODE_GT1 = 2'd1,
        MODE_GT2 = 2'd2,
        MODE_GT3 = 2'd3
    } trig_mode_e;

endpackage

// ==== hdl/frame_delay_line.sv ====
module frame_delay_line #(
    parameter int WORD_W = 8
) (
    input  logic              clk,
    input  logic              rstb,
    input  logic [WORD_W-1:0] d_i,
    output logic [WORD_W-1:0] tap0_o,
    output logic [WORD_W-1:0] tap1_o,
    output logic [WORD_W-1:0] tap2_o
);

    logic [WORD_W-1:0] tap0_q;
    logic [WORD_W-1:0] tap1_q;
    logic [WORD_W-1:0] tap2_q;

    // Tap n holds the input from n+1 cycles ago.
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            tap0_q <= '0;
            tap1_q <= '0;
            tap2_q <= '0;
        end else begin
            tap0_q <= d_i;
            tap1_q <= tap0_q;
            tap2_q <= tap1_q;
        end
    end

    assign tap0_o = tap0_q;
    assign tap1_o = tap1_q;
    assign tap2_o = tap2_q;

endmodule

// ==== hdl/trigger_detect.sv ====
module trigger_detect #(
    parameter int LANES = 4
) (
    input  logic                                     clk,
    input  logic                                     rstb,
    input  logic [errt_data_pkg::PRBS_W*LANES-1:0]   prbs_trig_i,
    input  logic [errt_ctrl_pkg::MODE_W-1:0]         mode_i,
    output logic                                     trig_o
);

    localparam int TRIG_BITS = errt_data_pkg::PRBS_W * LANES;
    localparam int CNT_W = $clog2(TRIG_BITS + 1);
    localparam int CMP_W = (CNT_W > errt_ctrl_pkg::MODE_W) ? CNT_W : errt_ctrl_pkg::MODE_W;

    logic [TRIG_BITS-1:0] trig_bits_q;
    logic [CNT_W-1:0]     ones;
    logic                 hit;
    logic                 trig_q;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            trig_bits_q <= '0;
            trig_q      <= 1'b0;
        end else begin
            trig_bits_q <= prbs_trig_i;
            trig_q      <= hit;
        end
    end

    always_comb begin
        ones = '0;
        for (int i = 0; i < TRIG_BITS; i++) begin
            ones = ones + CNT_W'(trig_bits_q[i]);
        end
    end

    // The mode value is the threshold itself.
    assign hit = CMP_W'(ones) > CMP_W'(mode_i);

    // The second register lines the pulse up with the delay-line window.
    assign trig_o = trig_q;

    mode_known_a: assert property (@(posedge clk) disable iff (!rstb)
        !$isunknown(mode_i));

endmodule

// ==== hdl/capture_memory.sv ====
module capture_memory #(
    parameter int LANES  = 4,
    parameter int ADDR_W = 6
) (
    input  logic                         clk,
    input  logic                         rstb,
    input  logic                         trig_i,
    input  logic                         arm_i,
    input  logic [errt_ctrl_pkg::WIN_FRAMES*LANES*errt_data_pkg::SYM_W-1:0]  win_sym_i,
    input  logic [errt_ctrl_pkg::WIN_FRAMES*LANES*errt_data_pkg::ERR_W-1:0]  win_err_i,
    input  logic [errt_ctrl_pkg::WIN_FRAMES*LANES*errt_data_pkg::FLAG_W-1:0] win_flags_i,
    input  logic [errt_ctrl_pkg::WIN_FRAMES*LANES*errt_data_pkg::PRBS_W-1:0] win_prbs_i,
    output logic                         armed_o,
    output logic                         busy_o,
    output logic                         full_o,
    output logic [ADDR_W-1:0]            cap_count_o,
    input  logic                         rd_req_valid_i,
    input  logic [ADDR_W-1:0]            rd_addr_i,
    output logic                         rd_req_ready_o,
    output logic                         rd_rsp_valid_o,
    input  logic                         rd_rsp_ready_i,
    output logic [errt_data_pkg::REC_W-1:0] rd_data_o
);

    localparam int SYM_W = errt_data_pkg::SYM_W;
    localparam int ERR_W = errt_data_pkg::ERR_W;
    localparam int FLAG_W = errt_data_pkg::FLAG_W;
    localparam int PRBS_W = errt_data_pkg::PRBS_W;
    localparam int REC_PER_WIN = errt_ctrl_pkg::WIN_FRAMES * LANES;
    localparam int DEPTH = 2 ** ADDR_W;
    localparam int IDX_W = $clog2(REC_PER_WIN);
    localparam int PTR_W = ADDR_W + 1;

    errt_data_pkg::rec_word_u win_rec [REC_PER_WIN];
    errt_data_pkg::rec_word_u stage_q [REC_PER_WIN];
    errt_data_pkg::rec_word_u mem [DEPTH];

    logic                            armed_q;
    logic                            busy_q;
    logic                            full_q;
    logic [IDX_W-1:0]                idx_q;
    logic [PTR_W-1:0]                wr_ptr_q;
    logic [ADDR_W-1:0]               cap_count_q;
    logic                            start;
    logic                            last_rec;
    logic                            no_room;
    logic                            req_fire;
    logic                            rsp_valid_q;
    logic [errt_data_pkg::REC_W-1:0] rsp_data_q;

    // Record k is lane k%LANES of frame k/LANES, oldest frame first.
    always_comb begin
        for (int k = 0; k < REC_PER_WIN; k++) begin
            win_rec[k].rec.symbol   = win_sym_i[k*SYM_W +: SYM_W];
            win_rec[k].rec.error    = win_err_i[k*ERR_W +: ERR_W];
            win_rec[k].rec.sd_flags = win_flags_i[k*FLAG_W +: FLAG_W];
            win_rec[k].rec.prbs     = win_prbs_i[k*PRBS_W +: PRBS_W];
        end
    end

    assign start    = trig_i && armed_q && !busy_q;
    assign last_rec = busy_q && (idx_q == IDX_W'(REC_PER_WIN - 1));
    // Space left once the current last record has been written.
    assign no_room  = (DEPTH - int'(wr_ptr_q) - 1) < REC_PER_WIN;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            armed_q     <= 1'b0;
            busy_q      <= 1'b0;
            full_q      <= 1'b0;
            idx_q       <= '0;
            wr_ptr_q    <= '0;
            cap_count_q <= '0;
        end else if (arm_i) begin
            armed_q     <= 1'b1;
            busy_q      <= 1'b0;
            full_q      <= 1'b0;
            idx_q       <= '0;
            wr_ptr_q    <= '0;
            cap_count_q <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (busy_q) begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            if (last_rec) begin
                busy_q      <= 1'b0;
                cap_count_q <= cap_count_q + ADDR_W'(1);
                if (no_room) begin
                    armed_q <= 1'b0;
                    full_q  <= 1'b1;
                end
            end else begin
                idx_q <= idx_q + IDX_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            stage_q <= win_rec;
        end
        if (busy_q) begin
            mem[wr_ptr_q[ADDR_W-1:0]] <= stage_q[idx_q];
        end
        if (req_fire) begin
            rsp_data_q <= mem[rd_addr_i].raw;
        end
    end

    // A new request may enter as the held response leaves.
    assign rd_req_ready_o = !rsp_valid_q || rd_rsp_ready_i;
    assign req_fire       = rd_req_valid_i && rd_req_ready_o;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (rd_rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    assign armed_o        = armed_q;
    assign busy_o         = busy_q;
    assign full_o         = full_q;
    assign cap_count_o    = cap_count_q;
    assign rd_rsp_valid_o = rsp_valid_q;
    assign rd_data_o      = rsp_data_q;

    wr_ptr_in_range_a: assert property (@(posedge clk) disable iff (!rstb)
        busy_q |-> wr_ptr_q < PTR_W'(DEPTH));

    rsp_hold_a: assert property (@(posedge clk) disable iff (!rstb)
        rd_rsp_valid_o && !rd_rsp_ready_i |=> rd_rsp_valid_o && $stable(rd_data_o));

endmodule

// ==== hdl/error_tracker.sv ====
module error_tracker #(
    parameter int LANES  = 4,
    parameter int ADDR_W = 6
) (
    input  logic                                      clk,
    input  logic                                      rstb,
    input  logic [LANES*errt_data_pkg::SYM_W-1:0]     sym_i,
    input  logic [LANES*errt_data_pkg::ERR_W-1:0]     err_i,
    input  logic [LANES*errt_data_pkg::FLAG_W-1:0]    sd_flags_i,
    input  logic [LANES*errt_data_pkg::PRBS_W-1:0]    prbs_flags_i,
    input  logic [LANES*errt_data_pkg::PRBS_W-1:0]    prbs_trig_i,
    input  logic [errt_ctrl_pkg::MODE_W-1:0]          mode_i,
    input  logic                                      arm_i,
    output logic                                      armed_o,
    output logic                                      busy_o,
    output logic                                      full_o,
    output logic [ADDR_W-1:0]                         cap_count_o,
    input  logic                                      rd_req_valid_i,
    input  logic [ADDR_W-1:0]                         rd_addr_i,
    output logic                                      rd_req_ready_o,
    output logic                                      rd_rsp_valid_o,
    input  logic                                      rd_rsp_ready_i,
    output logic [errt_data_pkg::REC_W-1:0]           rd_data_o
);

    localparam int SYM_BUS = LANES * errt_data_pkg::SYM_W;
    localparam int ERR_BUS = LANES * errt_data_pkg::ERR_W;
    localparam int FLAG_BUS = LANES * errt_data_pkg::FLAG_W;
    localparam int PRBS_BUS = LANES * errt_data_pkg::PRBS_W;
    localparam int WF = errt_ctrl_pkg::WIN_FRAMES;

    logic [SYM_BUS-1:0]  sym_t0, sym_t1, sym_t2;
    logic [ERR_BUS-1:0]  err_t0, err_t1, err_t2;
    logic [FLAG_BUS-1:0] flag_t0, flag_t1, flag_t2;
    logic [PRBS_BUS-1:0] prbs_t0, prbs_t1, prbs_t2;
    logic [WF*SYM_BUS-1:0]  win_sym;
    logic [WF*ERR_BUS-1:0]  win_err;
    logic [WF*FLAG_BUS-1:0] win_flags;
    logic [WF*PRBS_BUS-1:0] win_prbs;
    logic                   trig;

    frame_delay_line #(.WORD_W(SYM_BUS)) u_sym_dl (
        .clk(clk), .rstb(rstb), .d_i(sym_i),
        .tap0_o(sym_t0), .tap1_o(sym_t1), .tap2_o(sym_t2)
    );

    frame_delay_line #(.WORD_W(ERR_BUS)) u_err_dl (
        .clk(clk), .rstb(rstb), .d_i(err_i),
        .tap0_o(err_t0), .tap1_o(err_t1), .tap2_o(err_t2)
    );

    frame_delay_line #(.WORD_W(FLAG_BUS)) u_flag_dl (
        .clk(clk), .rstb(rstb), .d_i(sd_flags_i),
        .tap0_o(flag_t0), .tap1_o(flag_t1), .tap2_o(flag_t2)
    );

    frame_delay_line #(.WORD_W(PRBS_BUS)) u_prbs_dl (
        .clk(clk), .rstb(rstb), .d_i(prbs_flags_i),
        .tap0_o(prbs_t0), .tap1_o(prbs_t1), .tap2_o(prbs_t2)
    );

    // Oldest frame sits in the low bits of each window bus.
    assign win_sym   = {sym_t0, sym_t1, sym_t2};
    assign win_err   = {err_t0, err_t1, err_t2};
    assign win_flags = {flag_t0, flag_t1, flag_t2};
    assign win_prbs  = {prbs_t0, prbs_t1, prbs_t2};

    trigger_detect #(.LANES(LANES)) u_trig (
        .clk(clk), .rstb(rstb), .prbs_trig_i(prbs_trig_i),
        .mode_i(mode_i), .trig_o(trig)
    );

    capture_memory #(.LANES(LANES), .ADDR_W(ADDR_W)) u_cap (
        .clk(clk), .rstb(rstb), .trig_i(trig), .arm_i(arm_i),
        .win_sym_i(win_sym), .win_err_i(win_err),
        .win_flags_i(win_flags), .win_prbs_i(win_prbs),
        .armed_o(armed_o), .busy_o(busy_o), .full_o(full_o),
        .cap_count_o(cap_count_o),
        .rd_req_valid_i(rd_req_valid_i), .rd_addr_i(rd_addr_i),
        .rd_req_ready_o(rd_req_ready_o), .rd_rsp_valid_o(rd_rsp_valid_o),
        .rd_rsp_ready_i(rd_rsp_ready_i), .rd_data_o(rd_data_o)
    );

endmodule

// ==== dv/errt_ref.svh ====
`ifndef ERRT_REF_SVH
`define ERRT_REF_SVH

// Number of PRBS trigger bits set in one frame.
function automatic int count_trig(input logic [31:0] bits);
    int n;
    n = 0;
    for (int i = 0; i < 32; i++) begin
        if (bits[i]) begin
            n++;
        end
    end
    return n;
endfunction

// Mode n fires when more than n trigger bits are set.
function automatic bit expect_fire(input logic [31:0] bits, input int mode);
    return count_trig(bits) > mode;
endfunction

// Record k of a window is lane k%lanes of frame tf-1+k/lanes.
function automatic int window_frame(input int tf, input int k, input int lanes);
    return tf - 1 + k / lanes;
endfunction

function automatic int max_windows(input int addr_w, input int lanes);
    return (2 ** addr_w) / (errt_ctrl_pkg::WIN_FRAMES * lanes);
endfunction

// The expected record word has the PRBS bits on top and the symbol at the bottom.
function automatic logic [errt_data_pkg::REC_W-1:0] expect_record(
    input logic [63:0] sym,
    input logic [63:0] err,
    input logic [63:0] flags,
    input logic [63:0] prbs,
    input int          lane
);
    return {prbs[lane*errt_data_pkg::PRBS_W +: errt_data_pkg::PRBS_W],
            flags[lane*errt_data_pkg::FLAG_W +: errt_data_pkg::FLAG_W],
            err[lane*errt_data_pkg::ERR_W +: errt_data_pkg::ERR_W],
            sym[lane*errt_data_pkg::SYM_W +: errt_data_pkg::SYM_W]};
endfunction

`endif

// ==== dv/tb_error_tracker.sv ====
module tb_error_tracker;

    localparam int LANES   = 4;
    localparam int ADDR_W  = 6;
    localparam int REC_W   = errt_data_pkg::REC_W;
    localparam int TW      = LANES * errt_data_pkg::PRBS_W;
    localparam int RPW     = errt_ctrl_pkg::WIN_FRAMES * LANES;
    localparam int HIST    = 4096;
    localparam int TIMEOUT = 200;
    localparam int SETTLE  = RPW + 6;

    logic                                    clk;
    logic                                    rstb;
    logic [LANES*errt_data_pkg::SYM_W-1:0]   sym_i;
    logic [LANES*errt_data_pkg::ERR_W-1:0]   err_i;
    logic [LANES*errt_data_pkg::FLAG_W-1:0]  sd_flags_i;
    logic [TW-1:0]                           prbs_flags_i;
    logic [TW-1:0]                           prbs_trig_i;
    logic [errt_ctrl_pkg::MODE_W-1:0]        mode_i;
    logic                                    arm_i;
    logic                                    armed_o;
    logic                                    busy_o;
    logic                                    full_o;
    logic [ADDR_W-1:0]                       cap_count_o;
    logic                                    rd_req_valid_i;
    logic [ADDR_W-1:0]                       rd_addr_i;
    logic                                    rd_req_ready_o;
    logic                                    rd_rsp_valid_o;
    logic                                    rd_rsp_ready_i;
    logic [REC_W-1:0]                        rd_data_o;

    // Values applied by the next step.
    logic                             arm_n;
    logic                             req_valid_n;
    logic [ADDR_W-1:0]                req_addr_n;
    logic [errt_ctrl_pkg::MODE_W-1:0] mode_n;
    bit                               pause_rsp;

    logic [63:0]      hist_sym [HIST];
    logic [63:0]      hist_err [HIST];
    logic [63:0]      hist_flags [HIST];
    logic [63:0]      hist_prbs [HIST];
    int               frame_no;
    int               errors;
    int               tests_run;
    int               tests_failed;
    bit               held;
    logic [REC_W-1:0] held_data;

    `include "errt_ref.svh"

    error_tracker #(.LANES(LANES), .ADDR_W(ADDR_W)) i_dut (
        .clk(clk), .rstb(rstb), .sym_i(sym_i), .err_i(err_i),
        .sd_flags_i(sd_flags_i), .prbs_flags_i(prbs_flags_i),
        .prbs_trig_i(prbs_trig_i), .mode_i(mode_i), .arm_i(arm_i),
        .armed_o(armed_o), .busy_o(busy_o), .full_o(full_o),
        .cap_count_o(cap_count_o),
        .rd_req_valid_i(rd_req_valid_i), .rd_addr_i(rd_addr_i),
        .rd_req_ready_o(rd_req_ready_o), .rd_rsp_valid_o(rd_rsp_valid_o),
        .rd_rsp_ready_i(rd_rsp_ready_i), .rd_data_o(rd_data_o)
    );

    always #50 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        errors++;
    endtask

    // Drive a random frame on the rising edge and return at the falling edge.
    task automatic step(input logic [TW-1:0] trig);
        logic [63:0] s;
        logic [63:0] e;
        logic [63:0] f;
        logic [63:0] p;
        @(posedge clk);
        frame_no++;
        s = {$urandom, $urandom};
        e = {$urandom, $urandom};
        f = {$urandom, $urandom};
        p = {$urandom, $urandom};
        hist_sym[frame_no % HIST]   = s;
        hist_err[frame_no % HIST]   = e;
        hist_flags[frame_no % HIST] = f;
        hist_prbs[frame_no % HIST]  = p;
        sym_i          <= s[LANES*errt_data_pkg::SYM_W-1:0];
        err_i          <= e[LANES*errt_data_pkg::ERR_W-1:0];
        sd_flags_i     <= f[LANES*errt_data_pkg::FLAG_W-1:0];
        prbs_flags_i   <= p[TW-1:0];
        prbs_trig_i    <= trig;
        mode_i         <= mode_n;
        arm_i          <= arm_n;
        rd_req_valid_i <= req_valid_n;
        rd_addr_i      <= req_addr_n;
        rd_rsp_ready_i <= pause_rsp ? ($urandom % 3 != 0) : 1'b1;
        arm_n = 1'b0;
        @(negedge clk);
    endtask

    task automatic settle(input int cycles);
        repeat (cycles) step('0);
    endtask

    task automatic pulse_arm();
        arm_n = 1'b1;
        step('0);
        step('0);
    endtask

    function automatic logic [TW-1:0] bits_set(input int n);
        logic [TW-1:0] b;
        b = '0;
        while (count_trig(32'(b)) < n) begin
            b = b | (TW'(1) << ($urandom % TW));
        end
        return b;
    endfunction

    task automatic wait_count(input int target);
        int n;
        n = 0;
        while (int'(cap_count_o) != target && n < TIMEOUT) begin
            step('0);
            n++;
        end
        if (int'(cap_count_o) != target) begin
            $display("Timeout at %0t: capture count never reached %0d", $time, target);
            errors++;
        end
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [REC_W-1:0] data);
        int n;
        req_valid_n = 1'b1;
        req_addr_n  = addr;
        step('0);
        n = 0;
        while (!rd_req_ready_o && n < TIMEOUT) begin
            step('0);
            n++;
        end
        if (!rd_req_ready_o) begin
            $display("Timeout at %0t: read request for address %0d never accepted",
                     $time, addr);
            errors++;
        end
        req_valid_n = 1'b0;
        step('0);
        n = 0;
        while (!(rd_rsp_valid_o && rd_rsp_ready_i) && n < TIMEOUT) begin
            step('0);
            n++;
        end
        data = rd_data_o;
        if (!(rd_rsp_valid_o && rd_rsp_ready_i)) begin
            $display("Timeout at %0t: no read response for address %0d", $time, addr);
            errors++;
        end
    endtask

    task automatic check_window(input int base, input int tf);
        logic [REC_W-1:0]         got;
        errt_data_pkg::rec_word_u g;
        errt_data_pkg::rec_word_u e;
        int                       f;
        for (int k = 0; k < RPW; k++) begin
            read_word(ADDR_W'(base + k), got);
            f = window_frame(tf, k, LANES) % HIST;
            e.raw = expect_record(hist_sym[f], hist_err[f], hist_flags[f], hist_prbs[f],
                                  k % LANES);
            g.raw = got;
            if (g.rec.symbol !== e.rec.symbol)
                report_mismatch("rd_data_o.symbol", 64'(e.rec.symbol), 64'(g.rec.symbol));
            if (g.rec.error !== e.rec.error)
                report_mismatch("rd_data_o.error", 64'(e.rec.error), 64'(g.rec.error));
            if (g.rec.sd_flags !== e.rec.sd_flags)
                report_mismatch("rd_data_o.sd_flags", 64'(e.rec.sd_flags), 64'(g.rec.sd_flags));
            if (g.rec.prbs !== e.rec.prbs)
                report_mismatch("rd_data_o.prbs", 64'(e.rec.prbs), 64'(g.rec.prbs));
        end
    endtask

    task automatic end_test(input string name, input int err_at_start);
        tests_run++;
        if (errors != err_at_start) begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    // A response held by the host keeps its valid and its data and blocks new requests.
    always @(negedge clk) begin
        if (held && !rd_rsp_valid_o) begin
            $display("Read response at %0t dropped before it was accepted", $time);
            errors++;
        end
        if (held && rd_rsp_valid_o && rd_data_o !== held_data)
            report_mismatch("rd_data_o", 64'(held_data), 64'(rd_data_o));
        if (rstb && rd_rsp_valid_o && !rd_rsp_ready_i && rd_req_ready_o !== 1'b0)
            report_mismatch("rd_req_ready_o", 0, 64'(rd_req_ready_o));
        held      = rstb && rd_rsp_valid_o && !rd_rsp_ready_i;
        held_data = rd_data_o;
    end

    initial begin
        int            tf;
        int            e0;
        int            maxw;
        int            exp_cnt;
        int            tf_list [16];
        logic [TW-1:0] b;
        void'($urandom(32'hc100));
        clk = 1'b0;
        rstb = 1'b0;
        sym_i = '0;
        err_i = '0;
        sd_flags_i = '0;
        prbs_flags_i = '0;
        prbs_trig_i = '0;
        mode_i = '0;
        arm_i = 1'b0;
        rd_req_valid_i = 1'b0;
        rd_addr_i = '0;
        rd_rsp_ready_i = 1'b1;
        arm_n = 1'b0;
        req_valid_n = 1'b0;
        req_addr_n = '0;
        mode_n = '0;
        pause_rsp = 1'b0;
        frame_no = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        held = 1'b0;
        repeat (16) @(posedge clk);
        rstb <= 1'b1;
        @(negedge clk);

        e0 = errors;
        if (armed_o !== 1'b0) report_mismatch("armed_o", 0, 64'(armed_o));
        if (busy_o !== 1'b0) report_mismatch("busy_o", 0, 64'(busy_o));
        if (full_o !== 1'b0) report_mismatch("full_o", 0, 64'(full_o));
        if (rd_rsp_valid_o !== 1'b0) report_mismatch("rd_rsp_valid_o", 0, 64'(rd_rsp_valid_o));
        for (int i = 0; i < 3; i++) begin
            step(bits_set(2));
            settle(4);
        end
        settle(SETTLE);
        if (cap_count_o !== '0) report_mismatch("cap_count_o", 0, 64'(cap_count_o));
        end_test("no_arm", e0);

        e0 = errors;
        pulse_arm();
        b = bits_set(1);
        step(b);
        tf = frame_no;
        exp_cnt = expect_fire(32'(b), 0) ? 1 : 0;
        wait_count(exp_cnt);
        if (cap_count_o !== ADDR_W'(exp_cnt))
            report_mismatch("cap_count_o", 64'(exp_cnt), 64'(cap_count_o));
        check_window(0, tf);
        end_test("single_capture", e0);

        e0 = errors;
        for (int m = 0; m < 4; m++) begin
            mode_n = errt_ctrl_pkg::MODE_W'(m);
            pulse_arm();
            for (int n = m; n <= m + 1; n++) begin
                b = bits_set(n);
                step(b);
                exp_cnt = expect_fire(32'(b), m) ? 1 : 0;
                wait_count(exp_cnt);
                settle(SETTLE);
                if (cap_count_o !== ADDR_W'(exp_cnt))
                    report_mismatch("cap_count_o", 64'(exp_cnt), 64'(cap_count_o));
            end
        end
        mode_n = '0;
        end_test("mode_threshold", e0);

        e0 = errors;
        pulse_arm();
        step(bits_set(1));
        tf = frame_no;
        settle(3);
        if (busy_o !== 1'b1) begin
            $display("Capture was not running when the second trigger came at %0t", $time);
            errors++;
        end
        step(bits_set(2));
        wait_count(1);
        settle(SETTLE);
        if (cap_count_o !== ADDR_W'(1)) report_mismatch("cap_count_o", 1, 64'(cap_count_o));
        check_window(0, tf);
        end_test("busy_drop", e0);

        e0 = errors;
        maxw = max_windows(ADDR_W, LANES);
        pulse_arm();
        for (int w = 0; w < maxw + 2; w++) begin
            step(bits_set(1));
            if (w < maxw) begin
                tf_list[w] = frame_no;
            end
            exp_cnt = (w < maxw) ? w + 1 : maxw;
            wait_count(exp_cnt);
            settle(SETTLE);
            if (cap_count_o !== ADDR_W'(exp_cnt))
                report_mismatch("cap_count_o", 64'(exp_cnt), 64'(cap_count_o));
            if (full_o !== (w + 1 >= maxw))
                report_mismatch("full_o", 64'(w + 1 >= maxw), 64'(full_o));
            if (armed_o !== (w + 1 < maxw))
                report_mismatch("armed_o", 64'(w + 1 < maxw), 64'(armed_o));
        end
        end_test("fill_memory", e0);

        e0 = errors;
        pause_rsp = 1'b1;
        for (int w = 0; w < maxw; w++) begin
            check_window(w * RPW, tf_list[w]);
        end
        pause_rsp = 1'b0;
        end_test("paused_readback", e0);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+dv
hdl/errt_data_pkg.sv
hdl/errt_ctrl_pkg.sv
hdl/frame_delay_line.sv
hdl/trigger_detect.sv
hdl/capture_memory.sv
hdl/error_tracker.sv
dv/tb_error_tracker.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_error_tracker
RTL_TOP   ?= error_tracker
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert
PASS_TEXT := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '$(PASS_TEXT)' $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
